//--- Bender.yml
package:
  name: sbuf

sources:
  # Design sources in compile order
  - files:
      - design/sbuf_pkg.sv
      - design/sbuf_fifo.sv
      - design/sbuf_arbiter.sv
      - design/sbuf_burst_ctrl.sv
      - design/sbuf_ostream.sv
      - design/sbuf_top.sv

  # Testbench sources
  - target: simulation
    files:
      - sim/sbuf_mem_model.sv
      - sim/sbuf_tb.sv

//--- design/sbuf_arbiter.sv
//--------------------------------------------------
// Decode stage of the stream buffer
// Picks the next memory operation, alternating
// priority between read and write bursts
//--------------------------------------------------
`default_nettype none

module sbuf_arbiter (
    input  wire logic               reset,          // Clock
    input  wire logic               clk,            // Async reset, active high
    input  wire logic               i_in_empty,     // Input FIFO empty
    input  wire logic               i_ring_full,
    input  wire logic               i_ring_empty,
    input  wire logic               i_rd_stop,      // No read credit left
    input  wire logic               i_wr_last,      // Last write beat pending
    input  wire logic               i_m_busy,
    output sbuf_pkg::mem_op_e       o_op
);

    sbuf_pkg::arb_state_e   state;
    logic                   wr_ok;
    logic                   rd_ok;

    assign wr_ok = ~i_ring_full & ~i_in_empty;     // Room in ring, data waiting
    assign rd_ok = ~i_ring_empty & ~i_rd_stop;     // Stored data, output room

    //--------------------------------------------------
    // State transitions
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state <= sbuf_pkg::ST_RD_IDLE;
        end else begin
            case (state)
                sbuf_pkg::ST_RD_IDLE: begin
                    if (wr_ok) begin
                        state <= sbuf_pkg::ST_WR_EXEC;     // Writes first here
                    end else if (rd_ok) begin
                        state <= sbuf_pkg::ST_RD_EXEC;
                    end
                end
                sbuf_pkg::ST_RD_EXEC: begin
                    // Read request takes a single accepted beat
                    if (~i_m_busy) begin
                        state <= wr_ok ? sbuf_pkg::ST_WR_EXEC : sbuf_pkg::ST_RD_IDLE;
                    end
                end
                sbuf_pkg::ST_WR_IDLE: begin
                    if (rd_ok) begin
                        state <= sbuf_pkg::ST_RD_EXEC;     // Reads first here
                    end else if (wr_ok) begin
                        state <= sbuf_pkg::ST_WR_EXEC;
                    end
                end
                sbuf_pkg::ST_WR_EXEC: begin
                    if (~i_m_busy & i_wr_last) begin
                        state <= rd_ok ? sbuf_pkg::ST_RD_EXEC : sbuf_pkg::ST_WR_IDLE;
                    end
                end
                default: state <= sbuf_pkg::ST_RD_IDLE;   // Unused codes
            endcase
        end
    end

    //--------------------------------------------------
    // Operation decode
    always_comb begin
        case (state)
            sbuf_pkg::ST_RD_EXEC: o_op = sbuf_pkg::OP_READ;
            sbuf_pkg::ST_WR_EXEC: o_op = sbuf_pkg::OP_WRITE;
            default:              o_op = sbuf_pkg::OP_NONE;
        endcase
    end

endmodule : sbuf_arbiter

`default_nettype wire

//--- design/sbuf_burst_ctrl.sv
//--------------------------------------------------
// Execute stage of the stream buffer
// Ring addresses, occupancy, burst sizing and the
// memory master request outputs
//--------------------------------------------------
`default_nettype none

module sbuf_burst_ctrl #(
    parameter int IN_DEPTH = sbuf_pkg::MAX_BURST
) (
    input  wire logic                               reset,      // Clock
    input  wire logic                               clk,        // Async reset
    input  wire sbuf_pkg::mem_op_e                  i_op,
    input  wire logic                               i_m_busy,
    input  wire logic [$clog2(IN_DEPTH + 1) - 1 : 0] i_in_used,  // Input FIFO fill
    input  wire sbuf_pkg::bcnt_t                    i_rd_credit,
    output sbuf_pkg::addr_t                         o_m_addr,
    output sbuf_pkg::bcnt_t                         o_m_bcnt,
    output logic                                    o_m_wreq,
    output logic                                    o_m_rreq,
    output logic                                    o_ring_full,
    output logic                                    o_ring_empty,
    output logic                                    o_wr_last,
    output sbuf_pkg::bcnt_t                         o_rd_bcnt
);

    sbuf_pkg::addr_t    wr_addr;        // Base of next write burst
    sbuf_pkg::addr_t    rd_addr;        // Base of next read burst
    sbuf_pkg::occ_t     used_cnt;
    sbuf_pkg::occ_t     free_cnt;
    sbuf_pkg::bcnt_t    wr_bcnt;
    sbuf_pkg::bcnt_t    rd_bcnt;
    sbuf_pkg::bcnt_t    wr_left;        // Write beats still to go
    logic               wr_beat;
    logic               rd_acc;

    function automatic sbuf_pkg::bcnt_t min3(input int a, input int b, input int c);
        int m;
        m = (a < b) ? a : b;
        m = (m < c) ? m : c;
        return sbuf_pkg::bcnt_t'(m);
    endfunction

    assign o_m_wreq = (i_op == sbuf_pkg::OP_WRITE);
    assign o_m_rreq = (i_op == sbuf_pkg::OP_READ);
    assign wr_beat  = o_m_wreq & ~i_m_busy;    // One word written
    assign rd_acc   = o_m_rreq & ~i_m_busy;    // Whole read burst taken

    assign o_m_addr  = o_m_wreq ? wr_addr : rd_addr;
    assign o_m_bcnt  = o_m_wreq ? wr_bcnt : rd_bcnt;
    assign o_wr_last = (wr_left == sbuf_pkg::bcnt_t'(1));
    assign o_rd_bcnt = rd_bcnt;

    //--------------------------------------------------
    // Ring occupancy and flags
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            used_cnt     <= '0;
            free_cnt     <= sbuf_pkg::occ_t'(sbuf_pkg::RING_WORDS);
            o_ring_full  <= 1'b0;
            o_ring_empty <= 1'b1;
        end else begin
            if (wr_beat) begin
                used_cnt <= used_cnt + 1'b1;
                free_cnt <= free_cnt - 1'b1;
            end else if (rd_acc) begin
                used_cnt <= used_cnt - sbuf_pkg::occ_t'(rd_bcnt);  // Whole burst freed
                free_cnt <= free_cnt + sbuf_pkg::occ_t'(rd_bcnt);
            end
            if (o_ring_full) begin
                o_ring_full <= ~rd_acc;
            end else begin
                o_ring_full <= wr_beat &
                               (used_cnt == sbuf_pkg::occ_t'(sbuf_pkg::RING_WORDS - 1));
            end
            if (o_ring_empty) begin
                o_ring_empty <= ~wr_beat;
            end else begin
                o_ring_empty <= rd_acc & (used_cnt <= sbuf_pkg::occ_t'(rd_bcnt));
            end
        end
    end

    //--------------------------------------------------
    // Burst sizing, latched while no request is up
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_bcnt <= '0;
            wr_left <= '0;
            rd_bcnt <= '0;
        end else begin
            if (~o_m_wreq) begin
                wr_bcnt <= min3(int'(i_in_used), sbuf_pkg::MAX_BURST, int'(free_cnt));
                wr_left <= min3(int'(i_in_used), sbuf_pkg::MAX_BURST, int'(free_cnt));
            end else if (wr_beat) begin
                wr_left <= wr_left - 1'b1;     // Count down beats
            end
            if (~o_m_rreq) begin
                rd_bcnt <= min3(int'(i_rd_credit), sbuf_pkg::MAX_BURST, int'(used_cnt));
            end
        end
    end

    //--------------------------------------------------
    // Ring addresses, wrap modulo ring size
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_addr <= '0;
            rd_addr <= '0;
        end else begin
            if (wr_beat & o_wr_last) begin
                wr_addr <= wr_addr + sbuf_pkg::addr_t'(wr_bcnt);
            end
            if (rd_acc) begin
                rd_addr <= rd_addr + sbuf_pkg::addr_t'(rd_bcnt);
            end
        end
    end

endmodule : sbuf_burst_ctrl

`default_nettype wire

//--- design/sbuf_fifo.sv
//--------------------------------------------------
// Show-ahead single-clock FIFO
// Head word visible without a pop, fill count out
//--------------------------------------------------
`default_nettype none

module sbuf_fifo #(
    parameter int DEPTH = 8
) (
    input  wire logic                           reset,  // Clock
    input  wire logic                           clk,    // Async reset, active high
    input  wire sbuf_pkg::data_t                i_dat,
    input  wire logic                           i_push,
    input  wire logic                           i_pop,
    output sbuf_pkg::data_t                     o_dat,
    output logic                                o_empty,
    output logic                                o_full,
    output logic [$clog2(DEPTH + 1) - 1 : 0]    o_used
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    sbuf_pkg::data_t        mem [DEPTH];    // Storage, no reset
    logic [PTR_W - 1 : 0]   wr_ptr;
    logic [PTR_W - 1 : 0]   rd_ptr;
    logic [CNT_W - 1 : 0]   used_cnt;
    logic                   do_push;
    logic                   do_pop;

    assign do_push = i_push & ~o_full;   // Push on full dropped
    assign do_pop  = i_pop & ~o_empty;   // Pop on empty dropped

    assign o_empty = (used_cnt == '0);
    assign o_full  = (used_cnt == CNT_W'(DEPTH));
    assign o_used  = used_cnt;
    assign o_dat   = mem[rd_ptr];        // Show-ahead head

    //--------------------------------------------------
    // Storage write
    always_ff @(posedge reset) begin
        if (do_push) begin
            mem[wr_ptr] <= i_dat;
        end
    end

    //--------------------------------------------------
    // Pointers and fill count
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            used_cnt <= '0;
        end else begin
            if (do_push) begin
                // Wrap for depths that are not a power of two
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   used_cnt <= used_cnt + 1'b1;
                2'b01:   used_cnt <= used_cnt - 1'b1;
                default: used_cnt <= used_cnt;  // Both or neither
            endcase
        end
    end

endmodule : sbuf_fifo

`default_nettype wire

//--- design/sbuf_ostream.sv
//--------------------------------------------------
// Result stage of the stream buffer
// Output FIFO and read credit with read stop
//--------------------------------------------------
`default_nettype none

module sbuf_ostream #(
    parameter int OUT_DEPTH = sbuf_pkg::MAX_BURST
) (
    input  wire logic               reset,      // Clock
    input  wire logic               clk,        // Async reset, active high
    input  wire sbuf_pkg::mem_op_e  i_op,
    input  wire logic               i_m_busy,
    input  wire sbuf_pkg::bcnt_t    i_rd_bcnt,  // Size of pending read
    input  wire sbuf_pkg::data_t    i_m_rdat,
    input  wire logic               i_m_rval,
    input  wire logic               i_rdy_out,
    output sbuf_pkg::data_t         o_dat,
    output logic                    o_val,
    output sbuf_pkg::bcnt_t         o_rd_credit,
    output logic                    o_rd_stop
);

    localparam int CR_W = $clog2(OUT_DEPTH + 1);

    logic [CR_W - 1 : 0]    credit;     // Output FIFO room not yet promised
    logic                   ofifo_empty;
    logic                   out_word;
    logic                   rd_acc;

    assign out_word = o_val & i_rdy_out;
    assign rd_acc   = (i_op == sbuf_pkg::OP_READ) & ~i_m_busy;
    assign o_val    = ~ofifo_empty;

    sbuf_fifo #(
        .DEPTH   (OUT_DEPTH)
    ) u_ofifo (
        .reset   (reset),
        .clk     (clk),
        .i_dat   (i_m_rdat),
        .i_push  (i_m_rval),
        .i_pop   (out_word),
        .o_dat   (o_dat),
        .o_empty (ofifo_empty),
        .o_full  (),
        .o_used  ()
    );

    // Bursts never exceed MAX_BURST, so clip the credit there
    assign o_rd_credit = (int'(credit) > sbuf_pkg::MAX_BURST) ?
                         sbuf_pkg::bcnt_t'(sbuf_pkg::MAX_BURST) : sbuf_pkg::bcnt_t'(credit);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            credit    <= CR_W'(OUT_DEPTH);
            o_rd_stop <= 1'b0;
        end else begin
            credit <= credit - (rd_acc ? CR_W'(i_rd_bcnt) : '0) + CR_W'(out_word);
            if (o_rd_stop) begin
                o_rd_stop <= ~out_word;     // Any drained word frees room
            end else begin
                o_rd_stop <= rd_acc & ~out_word & (credit <= CR_W'(i_rd_bcnt));
            end
        end
    end

endmodule : sbuf_ostream

`default_nettype wire

//--- design/sbuf_pkg.sv
//--------------------------------------------------
// Stream buffer shared definitions
// Widths, derived sizes, word types and the enums
// for arbiter state and memory operation
//--------------------------------------------------
`default_nettype none

package sbuf_pkg;

    //--------------------------------------------------
    // Widths and derived sizes
    localparam int DATA_W     = 8;                  // Stream and memory word
    localparam int ADDR_W     = 6;                  // Ring address
    localparam int BCNT_W     = 4;                  // Burst count field
    localparam int MAX_BURST  = 2 ** (BCNT_W - 1);  // 8 words
    localparam int RING_WORDS = 2 ** ADDR_W;        // 64 words

    //--------------------------------------------------
    // Data types
    typedef logic [DATA_W - 1 : 0] data_t;
    typedef logic [ADDR_W - 1 : 0] addr_t;
    typedef logic [BCNT_W - 1 : 0] bcnt_t;
    typedef logic [ADDR_W : 0]     occ_t;           // One extra bit for full ring

    // Bit 0 is the read request, bit 1 the write request,
    // bit 2 marks the write side of the alternation
    typedef enum logic [2 : 0] {
        ST_RD_IDLE = 3'b000,    // After a read, writes first
        ST_RD_EXEC = 3'b001,    // Read request out
        ST_WR_IDLE = 3'b100,    // After a write, reads first
        ST_WR_EXEC = 3'b110     // Write burst running
    } arb_state_e;

    typedef enum logic [1 : 0] {
        OP_NONE  = 2'b00,
        OP_READ  = 2'b01,
        OP_WRITE = 2'b10
    } mem_op_e;

endpackage : sbuf_pkg

`default_nettype wire

//--- design/sbuf_top.sv
//--------------------------------------------------
// Stream buffer top level
// Parks a data stream in a ring of external burst
// memory and plays it back in order
//--------------------------------------------------
`default_nettype none

module sbuf_top #(
    parameter int IN_DEPTH  = sbuf_pkg::MAX_BURST,
    parameter int OUT_DEPTH = sbuf_pkg::MAX_BURST
) (
    input  wire logic               reset,      // Clock
    input  wire logic               clk,        // Async reset, active high
    // Stream in
    input  wire sbuf_pkg::data_t    i_dat,
    input  wire logic               i_val,
    output logic                    o_rdy_in,
    // Stream out
    output sbuf_pkg::data_t         o_dat,
    output logic                    o_val,
    input  wire logic               i_rdy_out,
    // Memory master
    output sbuf_pkg::addr_t         o_m_addr,
    output sbuf_pkg::bcnt_t         o_m_bcnt,
    output logic                    o_m_wreq,
    output sbuf_pkg::data_t         o_m_wdat,
    output logic                    o_m_rreq,
    input  wire sbuf_pkg::data_t    i_m_rdat,
    input  wire logic               i_m_rval,
    input  wire logic               i_m_busy
);

    logic [$clog2(IN_DEPTH + 1) - 1 : 0] in_used;
    logic               in_empty;
    logic               in_full;
    logic               in_pop;
    sbuf_pkg::mem_op_e  op;
    logic               ring_full;
    logic               ring_empty;
    logic               wr_last;
    logic               rd_stop;
    sbuf_pkg::bcnt_t    rd_bcnt;
    sbuf_pkg::bcnt_t    rd_credit;

    assign o_rdy_in = ~in_full;
    assign in_pop   = o_m_wreq & ~i_m_busy;     // One word per write beat

    //--------------------------------------------------
    // Input buffer, head drives write data
    sbuf_fifo #(.DEPTH(IN_DEPTH)) u_ififo (
        .reset   (reset),      .clk     (clk),
        .i_dat   (i_dat),      .i_push  (i_val),
        .i_pop   (in_pop),     .o_dat   (o_m_wdat),
        .o_empty (in_empty),   .o_full  (in_full),
        .o_used  (in_used)
    );

    sbuf_arbiter u_arbiter (
        .reset        (reset),      .clk          (clk),
        .i_in_empty   (in_empty),   .i_ring_full  (ring_full),
        .i_ring_empty (ring_empty), .i_rd_stop    (rd_stop),
        .i_wr_last    (wr_last),    .i_m_busy     (i_m_busy),
        .o_op         (op)
    );

    sbuf_burst_ctrl #(.IN_DEPTH(IN_DEPTH)) u_burst_ctrl (
        .reset        (reset),      .clk          (clk),
        .i_op         (op),         .i_m_busy     (i_m_busy),
        .i_in_used    (in_used),    .i_rd_credit  (rd_credit),
        .o_m_addr     (o_m_addr),   .o_m_bcnt     (o_m_bcnt),
        .o_m_wreq     (o_m_wreq),   .o_m_rreq     (o_m_rreq),
        .o_ring_full  (ring_full),  .o_ring_empty (ring_empty),
        .o_wr_last    (wr_last),    .o_rd_bcnt    (rd_bcnt)
    );

    sbuf_ostream #(.OUT_DEPTH(OUT_DEPTH)) u_ostream (
        .reset        (reset),      .clk          (clk),
        .i_op         (op),         .i_m_busy     (i_m_busy),
        .i_rd_bcnt    (rd_bcnt),    .i_m_rdat     (i_m_rdat),
        .i_m_rval     (i_m_rval),   .i_rdy_out    (i_rdy_out),
        .o_dat        (o_dat),      .o_val        (o_val),
        .o_rd_credit  (rd_credit),  .o_rd_stop    (rd_stop)
    );

endmodule : sbuf_top

`default_nettype wire

//--- project.f
design/sbuf_pkg.sv
design/sbuf_fifo.sv
design/sbuf_arbiter.sv
design/sbuf_burst_ctrl.sv
design/sbuf_ostream.sv
design/sbuf_top.sv
sim/sbuf_mem_model.sv
sim/sbuf_tb.sv

//--- sim/sbuf_mem_model.sv
//--------------------------------------------------
// Burst memory model for the stream buffer
// Random busy stalls, read data returned in order
// after a random delay
//--------------------------------------------------
`default_nettype none

module sbuf_mem_model (
    input  wire logic               reset,      // Clock
    input  wire logic               clk,        // Async reset, active high
    input  wire sbuf_pkg::addr_t    i_m_addr,
    input  wire sbuf_pkg::bcnt_t    i_m_bcnt,
    input  wire logic               i_m_wreq,
    input  wire sbuf_pkg::data_t    i_m_wdat,
    input  wire logic               i_m_rreq,
    output sbuf_pkg::data_t         o_m_rdat,
    output logic                    o_m_rval,
    output logic                    o_m_busy
);

    timeunit 1ns;
    timeprecision 1ps;

    sbuf_pkg::data_t    mem [sbuf_pkg::RING_WORDS];
    sbuf_pkg::data_t    ret_q [$];      // Read words not yet returned
    int                 beat;           // Index inside write burst
    int                 gap;            // Cycles until next return

    initial begin
        o_m_rdat = '0;
        o_m_rval = 1'b0;
        o_m_busy = 1'b0;
        beat     = 0;
        gap      = 0;
        for (int a = 0; a < sbuf_pkg::RING_WORDS; a++) begin
            mem[a] = sbuf_pkg::data_t'(a * 37) ^ 8'h5a;  // Address-dependent fill
        end
    end

    //--------------------------------------------------
    // Accept beats on the rising edge
    always @(posedge reset or posedge clk) begin
        if (clk) begin
            beat = 0;
            ret_q.delete();
        end else begin
            if (i_m_wreq && !o_m_busy) begin
                mem[sbuf_pkg::addr_t'(int'(i_m_addr) + beat)] = i_m_wdat;  // Wraps mod 64
                beat = beat + 1;
                if (beat == int'(i_m_bcnt)) begin
                    beat = 0;
                end
            end
            if (i_m_rreq && !o_m_busy) begin
                if (ret_q.size() == 0) begin
                    gap = 1 + int'($urandom % 6);   // First word latency
                end
                for (int i = 0; i < int'(i_m_bcnt); i++) begin
                    ret_q.push_back(mem[sbuf_pkg::addr_t'(int'(i_m_addr) + i)]);
                end
            end
        end
    end

    //--------------------------------------------------
    // Drive busy and read data on the falling edge
    always @(negedge reset) begin
        if (clk) begin
            o_m_busy = 1'b0;
            o_m_rval = 1'b0;
            gap      = 0;
        end else begin
            o_m_busy = ($urandom % 4 == 0);    // Stall about a quarter of cycles
            o_m_rval = 1'b0;
            if (gap > 0) begin
                gap = gap - 1;
            end else if (ret_q.size() > 0) begin
                o_m_rval = 1'b1;
                o_m_rdat = ret_q.pop_front();
                gap      = int'($urandom % 3);  // Gap before next word
            end
        end
    end

endmodule : sbuf_mem_model

`default_nettype wire

//--- sim/sbuf_tb.sv
//--------------------------------------------------
// Stream buffer testbench
// Random stream traffic against a queue model, with
// a burst memory model and random busy stalls
//--------------------------------------------------
`default_nettype none

module sbuf_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_WORDS  = 2000;
    localparam int IN_DEPTH   = sbuf_pkg::MAX_BURST;
    localparam int OUT_DEPTH  = sbuf_pkg::MAX_BURST;
    localparam int TIMEOUT_NS = NUM_WORDS * 40 * CLK_PERIOD;

    logic               reset;          // Clock
    logic               clk;            // Active-high async reset
    sbuf_pkg::data_t    i_dat;
    logic               i_val;
    logic               o_rdy_in;
    sbuf_pkg::data_t    o_dat;
    logic               o_val;
    logic               i_rdy_out;
    sbuf_pkg::addr_t    m_addr;
    sbuf_pkg::bcnt_t    m_bcnt;
    logic               m_wreq;
    sbuf_pkg::data_t    m_wdat;
    logic               m_rreq;
    sbuf_pkg::data_t    m_rdat;
    logic               m_rval;
    logic               m_busy;

    //--------------------------------------------------
    // Reference model state
    sbuf_pkg::data_t    exp_q [$];              // Accepted but not yet output
    sbuf_pkg::data_t    in_log [NUM_WORDS];     // All accepted words in order
    int                 n_in;
    int                 n_out;
    int                 n_written;              // Write beats so far
    int                 ring_used;              // Written but not yet read
    int                 rd_pending;             // Requested but not returned
    int                 out_waiting;            // Returned but not yet output
    int                 wr_beat;
    sbuf_pkg::addr_t    exp_wr_addr;
    sbuf_pkg::addr_t    exp_rd_addr;
    sbuf_pkg::addr_t    burst_addr;
    sbuf_pkg::bcnt_t    burst_bcnt;
    logic               in_taken;
    logic               hold_chk;               // Request stalled at last edge
    logic               held_wreq;
    logic               held_rreq;
    sbuf_pkg::addr_t    held_addr;
    sbuf_pkg::bcnt_t    held_bcnt;
    int unsigned        seed;
    int unsigned        discard;

    sbuf_top #(
        .IN_DEPTH  (IN_DEPTH),
        .OUT_DEPTH (OUT_DEPTH)
    ) dut (
        .reset     (reset),
        .clk       (clk),
        .i_dat     (i_dat),
        .i_val     (i_val),
        .o_rdy_in  (o_rdy_in),
        .o_dat     (o_dat),
        .o_val     (o_val),
        .i_rdy_out (i_rdy_out),
        .o_m_addr  (m_addr),
        .o_m_bcnt  (m_bcnt),
        .o_m_wreq  (m_wreq),
        .o_m_wdat  (m_wdat),
        .o_m_rreq  (m_rreq),
        .i_m_rdat  (m_rdat),
        .i_m_rval  (m_rval),
        .i_m_busy  (m_busy)
    );

    sbuf_mem_model u_mem (
        .reset    (reset),      .clk      (clk),
        .i_m_addr (m_addr),     .i_m_bcnt (m_bcnt),
        .i_m_wreq (m_wreq),     .i_m_wdat (m_wdat),
        .i_m_rreq (m_rreq),     .o_m_rdat (m_rdat),
        .o_m_rval (m_rval),     .o_m_busy (m_busy)
    );

    always #(CLK_PERIOD / 2) reset = ~reset;

    //--------------------------------------------------
    // Failure reporting and compare tasks
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string what, input sbuf_pkg::data_t got,
                              input sbuf_pkg::data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0d ns: %s got 0x%02h, expected 0x%02h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input string what, input sbuf_pkg::addr_t got,
                              input sbuf_pkg::addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0d ns: %s got %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_bcnt(input string what, input sbuf_pkg::bcnt_t got,
                              input sbuf_pkg::bcnt_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0d ns: %s got %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0d ns: %s got %0b, expected %0b",
                                     $time, what, got, exp));
        end
    endtask

    //--------------------------------------------------
    // Stream side sampling on the rising edge
    task automatic sample_streams();
        if (o_val && i_rdy_out) begin
            if (exp_q.size() == 0) begin
                report_failure("Output word appeared with no input word waiting");
            end
            check_data("output word", o_dat, exp_q.pop_front());
            n_out       = n_out + 1;
            out_waiting = out_waiting - 1;
        end
        if (i_val && o_rdy_in) begin
            exp_q.push_back(i_dat);
            in_log[n_in] = i_dat;
            n_in         = n_in + 1;
            in_taken     = 1'b1;
        end
        if (m_rval) begin
            check_flag("returned word has a read behind it", rd_pending > 0, 1'b1);
            rd_pending  = rd_pending - 1;
            out_waiting = out_waiting + 1;
        end
    endtask

    //--------------------------------------------------
    // Memory side sampling on the rising edge
    task automatic sample_memory();
        if (hold_chk) begin     // Stalled request must not move
            check_flag("write request under busy", m_wreq, held_wreq);
            check_flag("read request under busy", m_rreq, held_rreq);
            check_addr("address under busy", m_addr, held_addr);
            check_bcnt("count under busy", m_bcnt, held_bcnt);
        end
        hold_chk  = (m_wreq | m_rreq) & m_busy;
        held_wreq = m_wreq;
        held_rreq = m_rreq;
        held_addr = m_addr;
        held_bcnt = m_bcnt;
        check_flag("read and write request together", m_wreq & m_rreq, 1'b0);

        if (m_wreq && !m_busy) begin
            if (wr_beat == 0) begin
                check_addr("write burst address", m_addr, exp_wr_addr);
                check_flag("write count in range",
                           (m_bcnt >= 1) && (m_bcnt <= sbuf_pkg::MAX_BURST), 1'b1);
                check_flag("write count within free ring words",
                           int'(m_bcnt) <= sbuf_pkg::RING_WORDS - ring_used, 1'b1);
                burst_addr = m_addr;
                burst_bcnt = m_bcnt;
            end else begin
                check_addr("address held through write burst", m_addr, burst_addr);
                check_bcnt("count held through write burst", m_bcnt, burst_bcnt);
            end
            check_flag("write beat has an input word behind it", n_written < n_in, 1'b1);
            check_data("write data", m_wdat, in_log[n_written]);
            n_written = n_written + 1;
            ring_used = ring_used + 1;
            wr_beat   = wr_beat + 1;
            if (wr_beat == int'(burst_bcnt)) begin  // Last beat moves the next base
                wr_beat     = 0;
                exp_wr_addr = sbuf_pkg::addr_t'(int'(exp_wr_addr) + int'(burst_bcnt));
            end
        end

        if (m_rreq && !m_busy) begin
            check_addr("read burst address", m_addr, exp_rd_addr);
            check_flag("read count in range",
                       (m_bcnt >= 1) && (m_bcnt <= sbuf_pkg::MAX_BURST), 1'b1);
            check_flag("read count within stored words", int'(m_bcnt) <= ring_used, 1'b1);
            ring_used   = ring_used - int'(m_bcnt);
            rd_pending  = rd_pending + int'(m_bcnt);
            exp_rd_addr = sbuf_pkg::addr_t'(int'(exp_rd_addr) + int'(m_bcnt));
        end
        check_flag("reads in flight fit the output FIFO",
                   rd_pending + out_waiting <= OUT_DEPTH, 1'b1);
    endtask

    //--------------------------------------------------
    // Stimulus on the falling edge
    task automatic drive_inputs();
        if (!i_val || in_taken) begin   // Hold an offered word until taken
            if ((n_in < NUM_WORDS) && ($urandom % 4 != 0)) begin
                i_val = 1'b1;
                i_dat = sbuf_pkg::data_t'($urandom);
            end else begin
                i_val = 1'b0;
            end
        end
        in_taken  = 1'b0;
        i_rdy_out = ($urandom % 3 != 0);  // Back-pressure a third of cycles
    endtask

    //--------------------------------------------------
    // Main sequence
    initial begin
        seed        = 79;
        discard     = $urandom(seed);
        reset       = 1'b0;
        clk         = 1'b1;
        i_dat       = '0;
        i_val       = 1'b0;
        i_rdy_out   = 1'b0;
        n_in        = 0;
        n_out       = 0;
        n_written   = 0;
        ring_used   = 0;
        rd_pending  = 0;
        out_waiting = 0;
        wr_beat     = 0;
        exp_wr_addr = '0;
        exp_rd_addr = '0;
        in_taken    = 1'b0;
        hold_chk    = 1'b0;

        repeat (4) @(negedge reset);
        check_flag("write request after reset", m_wreq, 1'b0);
        check_flag("read request after reset", m_rreq, 1'b0);
        check_flag("output valid after reset", o_val, 1'b0);
        check_flag("input ready after reset", o_rdy_in, 1'b1);
        clk <= 1'b0;    // Release between rising edges

        while (n_out < NUM_WORDS) begin
            @(posedge reset);
            sample_streams();
            sample_memory();
            @(negedge reset);
            drive_inputs();
        end

        check_flag("no read left in flight", rd_pending == 0, 1'b1);
        check_flag("ring drained", ring_used == 0, 1'b1);
        $display("Simulation PASSED");
        $finish;
    end

    // Watchdog bound scales with the streamed word count
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: only %0d of %0d words came out within %0d ns",
                 n_out, NUM_WORDS, TIMEOUT_NS);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule : sbuf_tb

`default_nettype wire
